//--- cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Width of one memory byte and of the accumulator
`define DATA_WIDTH 8

// Width of a memory address and of the program counter
`define ADDR_WIDTH 8

// Bytes in the shared instruction and data memory
`define MEM_DEPTH 256

// Result cell; the boot image fills everything below it
`define RESULT_ADDR 128

`endif

//--- cpu_pkg.sv
`include "cpu_defines.svh"

package cpu_pkg;

	typedef logic [`DATA_WIDTH-1:0] data_t;
	typedef logic [`ADDR_WIDTH-1:0] addr_t;

	typedef enum logic [7:0] {
		NOP = 8'h00,
		LDI = 8'h10, // Immediate operand
		LDA = 8'h20,
		STA = 8'h30,
		ADD = 8'h40,
		SUB = 8'h50,
		AND = 8'h60,
		OR  = 8'h70,
		XOR = 8'h80,
		JMP = 8'h90,
		JZ  = 8'hA0,
		JC  = 8'hB0,
		HLT = 8'hF0
	} opcode_t;

	typedef enum logic [2:0] {
		aluPass,
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluXor
	} aluOp_t;

	typedef enum logic [1:0] {
		sFetch,
		sOperand,
		sExecute,
		sHalt
	} cpuState_t;

endpackage

//--- project.f
+incdir+.
cpu_pkg.sv
upMemory.sv
upControl.sv
upAlu.sv
upRegisters.sv
upAddressUnit.sv
upTop.sv
upTb.sv

//--- upAddressUnit.sv
`timescale 1ns/1ns

module upAddressUnit
	import cpu_pkg::*;
(
	input  logic  clk,
	input  logic  nRst,
	input  logic  pcInc,
	input  logic  pcLoad,
	input  logic  addrSel,
	input  data_t operand,
	output addr_t pc,
	output addr_t address
);

	assign address = addrSel ? addr_t'(operand) : pc;

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			pc <= '0;
		end else if (pcLoad) begin
			pc <= addr_t'(operand); // Jump target
		end else if (pcInc) begin
			pc <= pc + 1'b1; // Wraps at the top of memory
		end
	end

endmodule

//--- upAlu.sv
`timescale 1ns/1ns

module upAlu
	import cpu_pkg::*;
(
	input  data_t  a,
	input  data_t  b,
	input  aluOp_t op,
	output data_t  result,
	output logic   carryOut
);

	logic [$bits(data_t):0] sum;
	logic [$bits(data_t):0] diff;

	assign sum = {1'b0, a} + {1'b0, b};
	assign diff = {1'b0, a} - {1'b0, b}; // MSB is the borrow

	always_comb begin
		carryOut = 1'b0;
		case (op)
			aluAdd: begin
				result = sum[$bits(data_t)-1:0];
				carryOut = sum[$bits(data_t)];
			end
			aluSub: begin
				result = diff[$bits(data_t)-1:0];
				carryOut = diff[$bits(data_t)];
			end
			aluAnd: result = a & b;
			aluOr: result = a | b;
			aluXor: result = a ^ b;
			default: result = b; // Pass for loads
		endcase
	end

endmodule

//--- upControl.sv
`timescale 1ns/1ns

module upControl
	import cpu_pkg::*;
(
	input  logic   clk,
	input  logic   nRst,
	input  logic   run,
	input  data_t  instr,
	input  logic   zero,
	input  logic   carry,
	output logic   irLoad,
	output logic   opLoad,
	output logic   accLoad,
	output logic   zeroLoad,
	output logic   carryLoad,
	output logic   immSel,
	output logic   pcInc,
	output logic   pcLoad,
	output logic   addrSel,
	output logic   memWe,
	output aluOp_t aluOp,
	output logic   halted
);

	cpuState_t state;
	cpuState_t nextState;
	opcode_t   opcode;

	// Unknown bytes fall to the default branch and act as NOP
	assign opcode = opcode_t'(instr);
	assign halted = (state == sHalt);

	function automatic logic twoByte(input opcode_t op);
		return op inside {LDI, LDA, STA, ADD, SUB, AND, OR, XOR, JMP, JZ, JC};
	endfunction

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			state <= sFetch;
		end else begin
			state <= nextState;
		end
	end

	always_comb begin
		irLoad = 1'b0;
		opLoad = 1'b0;
		accLoad = 1'b0;
		zeroLoad = 1'b0;
		carryLoad = 1'b0;
		immSel = 1'b0;
		pcInc = 1'b0;
		pcLoad = 1'b0;
		addrSel = 1'b0;
		memWe = 1'b0;
		aluOp = aluPass;
		nextState = state;
		case (state)
			sFetch: begin
				if (run) begin // Instruction boundary, the only place run is sampled
					irLoad = 1'b1;
					pcInc = 1'b1;
					nextState = twoByte(opcode) ? sOperand : sExecute;
				end
			end
			sOperand: begin
				opLoad = 1'b1;
				pcInc = 1'b1;
				nextState = sExecute;
			end
			sExecute: begin
				addrSel = 1'b1; // Operand register addresses memory
				nextState = sFetch;
				case (opcode)
					LDI: begin
						immSel = 1'b1;
						accLoad = 1'b1;
						zeroLoad = 1'b1;
					end
					LDA: begin
						accLoad = 1'b1;
						zeroLoad = 1'b1;
					end
					ADD, SUB: begin
						aluOp = (opcode == ADD) ? aluAdd : aluSub;
						accLoad = 1'b1;
						zeroLoad = 1'b1;
						carryLoad = 1'b1;
					end
					AND, OR, XOR: begin
						case (opcode)
							AND: aluOp = aluAnd;
							OR: aluOp = aluOr;
							default: aluOp = aluXor;
						endcase
						accLoad = 1'b1;
						zeroLoad = 1'b1;
					end
					STA: memWe = 1'b1;
					JMP: pcLoad = 1'b1;
					JZ: pcLoad = zero;
					JC: pcLoad = carry;
					HLT: nextState = sHalt;
					default: ;
				endcase
			end
			default: nextState = sHalt; // Held until reset
		endcase
	end

endmodule

//--- upMemory.sv
`timescale 1ns/1ns
`include "cpu_defines.svh"

module upMemory
	import cpu_pkg::*;
(
	input  logic  clk,
	input  logic  nRst,
	input  addr_t address,
	input  data_t in,
	input  logic  we,
	output data_t out,
	input  logic  hostWe,
	input  addr_t hostAddr,
	input  data_t hostData,
	output data_t hostRdata,
	output data_t test
);

	data_t mem [`MEM_DEPTH];

	// Demo program: sums 5+4+3+2+1 into the result cell and halts
	function automatic data_t bootByte(input addr_t a);
		case (a)
			8'h00: bootByte = LDI;
			8'h01: bootByte = 8'h05;
			8'h02: bootByte = STA; // count
			8'h03: bootByte = 8'h81;
			8'h04: bootByte = LDI;
			8'h05: bootByte = 8'h00;
			8'h06: bootByte = STA; // sum
			8'h07: bootByte = 8'h80;
			8'h08: bootByte = LDA; // Loop start
			8'h09: bootByte = 8'h80;
			8'h0A: bootByte = ADD;
			8'h0B: bootByte = 8'h81;
			8'h0C: bootByte = STA;
			8'h0D: bootByte = 8'h80;
			8'h0E: bootByte = LDA;
			8'h0F: bootByte = 8'h81;
			8'h10: bootByte = SUB; // count - 1
			8'h11: bootByte = 8'h7F;
			8'h12: bootByte = STA;
			8'h13: bootByte = 8'h81;
			8'h14: bootByte = JZ;
			8'h15: bootByte = 8'h18;
			8'h16: bootByte = JMP;
			8'h17: bootByte = 8'h08;
			8'h18: bootByte = HLT;
			8'h7F: bootByte = 8'h01; // Constant one
			default: bootByte = '0;
		endcase
	endfunction

	assign out = mem[address];
	assign hostRdata = mem[hostAddr];
	assign test = mem[`RESULT_ADDR];

	// Upper half is left as it was across reset
	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			for (int i = 0; i < `RESULT_ADDR; i++) begin
				mem[i] <= bootByte(addr_t'(i));
			end
		end else if (hostWe) begin
			mem[hostAddr] <= hostData;
		end else if (we) begin
			mem[address] <= in;
		end
	end

endmodule

//--- upRegisters.sv
`timescale 1ns/1ns

module upRegisters
	import cpu_pkg::*;
(
	input  logic  clk,
	input  logic  nRst,
	input  data_t memData,
	input  data_t aluResult,
	input  logic  aluCarry,
	input  logic  immSel,
	input  logic  irLoad,
	input  logic  opLoad,
	input  logic  accLoad,
	input  logic  zeroLoad,
	input  logic  carryLoad,
	output data_t instr,
	output data_t operand,
	output data_t aluB,
	output data_t acc,
	output logic  zero,
	output logic  carry
);

	data_t ir;

	// Opcode is seen during fetch so the length can be decoded in time
	assign instr = irLoad ? memData : ir;
	assign aluB = immSel ? operand : memData;

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			ir <= '0;
			acc <= '0;
			zero <= 1'b0;
			carry <= 1'b0;
		end else begin
			if (irLoad)
				ir <= memData;
			if (accLoad)
				acc <= aluResult;
			if (zeroLoad)
				zero <= (aluResult == '0);
			if (carryLoad)
				carry <= aluCarry;
		end
	end

	always_ff @(posedge clk) begin
		if (opLoad)
			operand <= memData;
	end

endmodule

//--- upTb.sv
`timescale 1ns/1ns
`include "cpu_defines.svh"

module upTb
	import cpu_pkg::*;
;

	typedef data_t image_t [`MEM_DEPTH];

	localparam int STEP_LIMIT = 300;
	localparam int NUM_PROGRAMS = 44; // Boot, flags, 40 random, loop, run-low
	localparam int WATCH_NS = NUM_PROGRAMS * STEP_LIMIT * 3 * 8 + NUM_PROGRAMS * 808 * 8;

	logic  clk;
	logic  nRst;
	logic  run;
	logic  hostWe;
	addr_t hostAddr;
	data_t hostData;
	data_t hostRdata;
	data_t result;
	logic  halted;
	addr_t pc;

	image_t img;
	image_t expImg;
	image_t bootImg;
	addr_t  expPc;
	int     wp;

	upTop dut_i (
		.clk(clk),
		.nRst(nRst),
		.run(run),
		.hostWe(hostWe),
		.hostAddr(hostAddr),
		.hostData(hostData),
		.hostRdata(hostRdata),
		.result(result),
		.halted(halted),
		.pc(pc)
	);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	// Instruction-set model that runs until HLT or the step limit
	function automatic image_t modelRun(input image_t m, output addr_t pcOut);
		addr_t pcM;
		data_t acc;
		data_t op;
		data_t opd;
		logic z;
		logic c;
		logic done;
		logic [8:0] t;
		pcM = '0;
		acc = '0;
		z = 1'b0;
		c = 1'b0;
		done = 1'b0;
		for (int step = 0; step < STEP_LIMIT && !done; step++) begin
			op = m[pcM];
			pcM = pcM + 1'b1;
			opd = '0;
			if (op inside {LDI, LDA, STA, ADD, SUB, AND, OR, XOR, JMP, JZ, JC}) begin
				opd = m[pcM];
				pcM = pcM + 1'b1;
			end
			case (op)
				LDI: acc = opd;
				LDA: acc = m[opd];
				ADD: begin
					t = {1'b0, acc} + {1'b0, m[opd]};
					acc = t[7:0];
					c = t[8];
				end
				SUB: begin
					c = (acc < m[opd]); // Borrow
					acc = acc - m[opd];
				end
				AND: acc = acc & m[opd];
				OR: acc = acc | m[opd];
				XOR: acc = acc ^ m[opd];
				STA: m[opd] = acc;
				JMP: pcM = opd;
				JZ: if (z) pcM = opd;
				JC: if (c) pcM = opd;
				HLT: done = 1'b1;
				default: ;
			endcase
			if (op inside {LDI, LDA, ADD, SUB, AND, OR, XOR})
				z = (acc == '0);
		end
		pcOut = pcM;
		return m;
	endfunction

	task automatic failNow(input string what);
		$display("%s", what);
		$display("Something failed");
		$fatal(1, "Run stopped");
	endtask

	task automatic checkData(input data_t got, input data_t exp, input string what);
		if (got !== exp)
			failNow($sformatf("Mismatch at %0t ns: %s, got %h expected %h",
				$time, what, got, exp));
	endtask

	task automatic checkAddr(input addr_t got, input addr_t exp, input string what);
		if (got !== exp)
			failNow($sformatf("Mismatch at %0t ns: %s, got %h expected %h",
				$time, what, got, exp));
	endtask

	task automatic checkFlag(input logic got, input logic exp, input string what);
		if (got !== exp)
			failNow($sformatf("Mismatch at %0t ns: %s, got %b expected %b",
				$time, what, got, exp));
	endtask

	task automatic applyReset();
		@(negedge clk) nRst = 1'b0;
		repeat (16) @(negedge clk);
		nRst = 1'b1;
	endtask

	task automatic readByte(input addr_t a, output data_t v);
		@(negedge clk) hostAddr = a;
		#2 v = hostRdata;
	endtask

	task automatic loadImage();
		@(negedge clk) hostWe = 1'b1;
		for (int i = 0; i < `MEM_DEPTH; i++) begin
			hostAddr = addr_t'(i);
			hostData = img[i];
			@(negedge clk);
		end
		hostWe = 1'b0;
	endtask

	task automatic compareRange(input int lo, input int hi);
		data_t v;
		for (int i = lo; i <= hi; i++) begin
			readByte(addr_t'(i), v);
			checkData(v, expImg[i], $sformatf("memory byte %0d", i));
		end
	endtask

	task automatic waitHalt();
		int n;
		n = 0;
		while (!halted && n < STEP_LIMIT * 3) begin
			@(negedge clk);
			n++;
		end
		if (!halted)
			failNow($sformatf("Processor did not halt within %0d cycles", STEP_LIMIT * 3));
	endtask

	// Pauses run after pauseAt cycles when pauseAt is non-zero
	task automatic runToHalt(input int pauseAt);
		addr_t holdPc;
		data_t holdRes;
		expImg = modelRun(img, expPc);
		@(negedge clk) run = 1'b1;
		if (pauseAt > 0) begin
			repeat (pauseAt) @(negedge clk);
			run = 1'b0;
			repeat (3) @(negedge clk); // Current instruction completes
			holdPc = pc;
			holdRes = result;
			repeat (30) @(negedge clk); // Longer than one loop pass
			checkAddr(pc, holdPc, "pc while run low");
			checkData(result, holdRes, "result while run low");
			checkFlag(halted, 1'b0, "halted while run low");
			run = 1'b1;
		end
		waitHalt();
		@(negedge clk) run = 1'b0;
	endtask

	task automatic emit(input data_t b);
		img[wp] = b;
		wp++;
	endtask

	task automatic emitPair(input data_t op, input data_t arg);
		emit(op);
		emit(arg);
	endtask

	task automatic fillImage();
		for (int i = 0; i < `MEM_DEPTH; i++)
			img[i] = (i < `RESULT_ADDR) ? data_t'(0) : data_t'($urandom);
		wp = 0;
	endtask

	// Stores 10h+k at 80h+k when the branch falls through and A0h+k when it is taken
	task automatic emitFlagCase(input int k, input data_t opc, input data_t a, input data_t b,
			input data_t jcc);
		img[8'h88 + k] = b;
		emitPair(LDI, a);
		if (opc != NOP)
			emitPair(opc, data_t'(8'h88 + k));
		emitPair(jcc, data_t'(wp + 6));
		emitPair(LDI, data_t'(8'h10 + k));
		emitPair(JMP, data_t'(wp + 4));
		emitPair(LDI, data_t'(8'hA0 + k));
		emitPair(STA, data_t'(8'h80 + k));
	endtask

	task automatic buildFlagProgram();
		fillImage();
		emitFlagCase(0, ADD, 8'hF0, 8'h20, JC);
		emitFlagCase(1, SUB, 8'h05, 8'h09, JC);
		emitFlagCase(2, AND, 8'hF0, 8'h0F, JZ);
		emitFlagCase(3, OR, 8'h30, 8'h03, JZ);
		emitFlagCase(4, XOR, 8'h5A, 8'h5A, JZ);
		emitFlagCase(5, NOP, 8'h00, 8'h00, JZ);
		emitFlagCase(6, ADD, 8'h10, 8'h20, JC);
		emitFlagCase(7, SUB, 8'h01, 8'h01, JC);
		emit(HLT);
	endtask

	task automatic buildRandomProgram();
		data_t op;
		fillImage();
		repeat (12) begin
			case ($urandom_range(7, 0))
				0: op = LDI;
				1: op = LDA;
				2: op = ADD;
				3: op = SUB;
				4: op = AND;
				5: op = OR;
				6: op = XOR;
				default: op = STA;
			endcase
			emitPair(op, (op == LDI) ? data_t'($urandom) : data_t'($urandom_range(255, 128)));
		end
		emit(HLT);
	endtask

	// Counts 90h down to zero and adds 93h into the result cell each pass
	task automatic buildLoopProgram(input data_t start);
		fillImage();
		img[8'h91] = 8'h01;
		img[8'h93] = data_t'($urandom_range(255, 1)); // Non-zero so every pass moves the result
		emitPair(LDI, start);
		emitPair(STA, 8'h90);
		emitPair(LDA, 8'h90); // Loop at 04h
		emitPair(SUB, 8'h91);
		emitPair(STA, 8'h90);
		emitPair(LDA, 8'h80);
		emitPair(ADD, 8'h93);
		emitPair(STA, 8'h80);
		emitPair(LDA, 8'h90);
		emitPair(JZ, 8'd22);
		emitPair(JMP, 8'd4);
		emit(HLT);
	endtask

	initial begin
		#(WATCH_NS);
		failNow("Watchdog expired before the tests finished");
	end

	initial begin : main
		data_t v;
		void'($urandom(54980));
		nRst = 1'b0;
		run = 1'b0;
		hostWe = 1'b0;
		hostAddr = '0;
		hostData = '0;
		repeat (16) @(negedge clk);
		nRst = 1'b1;

		for (int i = 0; i < `MEM_DEPTH; i++) begin
			readByte(addr_t'(i), v);
			img[i] = v;
		end
		bootImg = img;
		runToHalt(0);
		checkData(result, 8'd15, "boot program result");
		checkData(result, expImg[`RESULT_ADDR], "boot result against model");

		buildFlagProgram();
		applyReset();
		loadImage();
		runToHalt(0);
		compareRange(128, 135);

		for (int n = 0; n < 40; n++) begin
			buildRandomProgram();
			applyReset();
			loadImage();
			runToHalt(0);
			compareRange(128, 255);
		end

		buildLoopProgram(data_t'($urandom_range(20, 1)));
		applyReset();
		loadImage();
		runToHalt(0);
		compareRange(0, 255);
		checkAddr(pc, expPc, "halt pc");

		buildLoopProgram(8'd10);
		applyReset();
		loadImage();
		runToHalt(25);
		compareRange(0, 255);

		applyReset();
		for (int i = 0; i < `RESULT_ADDR; i++) begin
			readByte(addr_t'(i), v);
			checkData(v, bootImg[i], $sformatf("boot image byte %0d", i));
		end
		checkFlag(halted, 1'b0, "halted after reset");

		$display("Everything OK");
		$finish;
	end

endmodule

//--- upTop.sv
`timescale 1ns/1ns

module upTop
	import cpu_pkg::*;
(
	input  logic  clk,
	input  logic  nRst,
	input  logic  run,
	input  logic  hostWe,
	input  addr_t hostAddr,
	input  data_t hostData,
	output data_t hostRdata,
	output data_t result,
	output logic  halted,
	output addr_t pc
);

	data_t  instr;
	data_t  operand;
	data_t  acc;
	data_t  aluB;
	data_t  aluResult;
	data_t  memData;
	addr_t  address;
	aluOp_t aluOp;
	logic   zero;
	logic   carry;
	logic   aluCarry;
	logic   irLoad;
	logic   opLoad;
	logic   accLoad;
	logic   zeroLoad;
	logic   carryLoad;
	logic   immSel;
	logic   pcInc;
	logic   pcLoad;
	logic   addrSel;
	logic   memWe;

	upControl control (
		.clk(clk),
		.nRst(nRst),
		.run(run),
		.instr(instr),
		.zero(zero),
		.carry(carry),
		.irLoad(irLoad),
		.opLoad(opLoad),
		.accLoad(accLoad),
		.zeroLoad(zeroLoad),
		.carryLoad(carryLoad),
		.immSel(immSel),
		.pcInc(pcInc),
		.pcLoad(pcLoad),
		.addrSel(addrSel),
		.memWe(memWe),
		.aluOp(aluOp),
		.halted(halted)
	);

	upAlu alu (
		.a(acc),
		.b(aluB),
		.op(aluOp),
		.result(aluResult),
		.carryOut(aluCarry)
	);

	upRegisters registers (
		.clk(clk),
		.nRst(nRst),
		.memData(memData),
		.aluResult(aluResult),
		.aluCarry(aluCarry),
		.immSel(immSel),
		.irLoad(irLoad),
		.opLoad(opLoad),
		.accLoad(accLoad),
		.zeroLoad(zeroLoad),
		.carryLoad(carryLoad),
		.instr(instr),
		.operand(operand),
		.aluB(aluB),
		.acc(acc),
		.zero(zero),
		.carry(carry)
	);

	upAddressUnit addressUnit (
		.clk(clk),
		.nRst(nRst),
		.pcInc(pcInc),
		.pcLoad(pcLoad),
		.addrSel(addrSel),
		.operand(operand),
		.pc(pc),
		.address(address)
	);

	upMemory memory (
		.clk(clk),
		.nRst(nRst),
		.address(address),
		.in(acc), // Only STA writes, always the accumulator
		.we(memWe),
		.out(memData),
		.hostWe(hostWe),
		.hostAddr(hostAddr),
		.hostData(hostData),
		.hostRdata(hostRdata),
		.test(result)
	);

endmodule
